// File: Makefile
SIM = obj_dir/VtbSystem

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes
$(SIM): files.f $(shell cat files.f)
	verilator --binary --assert --top-module tbSystem -f files.f -o VtbSystem

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: busDecoder.sv
`default_nettype none

module busDecoder (
    input  logic                      clk,
    input  logic                      rstN,
    // CPU side
    input  logic [sysPkg::ADDR_W-1:0] dAddr,
    input  logic                      dWrEn,
    input  logic                      dRdEn,
    output logic [sysPkg::DATA_W-1:0] dRdData,
    // Region enables
    output logic                      ramWrEn,
    output logic                      ramRdEn,
    output logic                      ioWrEn,
    output logic                      ioRdEn,
    output logic                      vidWrEn,
    // Region read data
    input  logic [sysPkg::DATA_W-1:0] ramRdData,
    input  logic [sysPkg::DATA_W-1:0] ioRdData
);
    import sysPkg::*;

    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_RAM  = 2'd1;
    localparam logic [1:0] SEL_IO   = 2'd2;

    logic       inRam;
    logic       inIo;
    logic       inVid;
    logic [1:0] rdSel;      // Region of last cycle's address

    assign inRam = (dAddr >= DMEM_LO) && (dAddr <= DMEM_HI);
    assign inIo  = (dAddr >= IO_LO)   && (dAddr <= IO_HI);
    assign inVid = (dAddr >= VMEM_LO) && (dAddr <= VMEM_HI);

    // Unmapped addresses get no enable at all
    assign ramWrEn = dWrEn && inRam;
    assign ramRdEn = dRdEn && inRam;
    assign ioWrEn  = dWrEn && inIo;
    assign ioRdEn  = dRdEn && inIo;
    assign vidWrEn = dWrEn && inVid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdSel <= SEL_NONE;
        end else begin
            rdSel <= inRam ? SEL_RAM : (inIo ? SEL_IO : SEL_NONE);
        end
    end

    // Video memory and holes read as zero
    assign dRdData = (rdSel == SEL_RAM) ? ramRdData :
                     (rdSel == SEL_IO)  ? ioRdData  : '0;

endmodule

`default_nettype wire

// File: cpu.sv
`default_nettype none

module cpu (
    input  logic                       clk,
    input  logic                       rstN,
    // Instruction bus
    output logic [sysPkg::ADDR_W-1:0]  iAddr,
    output logic                       iRdEn,
    input  logic [sysPkg::INSTR_W-1:0] iData,
    // Data bus
    output logic [sysPkg::ADDR_W-1:0]  dAddr,
    output logic [sysPkg::DATA_W-1:0]  dWrData,
    output logic                       dWrEn,
    output logic                       dRdEn,
    input  logic [sysPkg::DATA_W-1:0]  dRdData,
    // Interrupt
    input  logic                       irqFlag,
    output logic                       irqClr
);
    import sysPkg::*;

    localparam int OPND_W = INSTR_W - 4;
    localparam int PAGE_W = ADDR_W - OPND_W;

    cpuStateT            state;
    logic [ADDR_W-1:0]   pc;
    logic [PAGE_W-1:0]   page;
    logic [DATA_W-1:0]   acc;
    logic                irqActive;     // Inside the service routine
    logic [INSTR_W-1:0]  ir;

    // Single interrupt level, no stack
    logic [ADDR_W-1:0]   pcShadow;
    logic [PAGE_W-1:0]   pageShadow;
    logic [DATA_W-1:0]   accShadow;

    opcodeT              op;
    logic [OPND_W-1:0]   operand;
    logic                takeIrq;
    logic                memOp;

    assign op      = opcodeT'(ir[INSTR_W-1:OPND_W]);
    assign operand = ir[OPND_W-1:0];
    assign takeIrq = (state == FETCH) && irqFlag && !irqActive;
    assign memOp   = (op == LD) || (op == ADD) || (op == SUB);

    //****************************************
    // Bus outputs
    assign iAddr   = pc;
    assign iRdEn   = (state == FETCH) && !takeIrq;  // Fetch is dropped on interrupt entry
    assign dAddr   = {page, operand};
    assign dWrData = acc;
    assign dWrEn   = (state == EXEC) && (op == ST);
    assign dRdEn   = (state == EXEC) && memOp;
    assign irqClr  = (state == IRQENTRY);

    //****************************************
    // Control state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= FETCH;
            pc        <= '0;
            page      <= '0;
            acc       <= '0;
            irqActive <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    state <= takeIrq ? IRQENTRY : DECODE;
                end
                DECODE: begin
                    pc    <= pc + 1'b1;     // iData is valid here
                    state <= EXEC;
                end
                EXEC: begin
                    state <= FETCH;
                    case (op)
                        LDI:  acc  <= operand[DATA_W-1:0];
                        PAGE: page <= operand[PAGE_W-1:0];
                        JMP:  pc   <= {{PAGE_W{1'b0}}, operand};
                        JZ: begin
                            if (acc == '0) begin
                                pc <= {{PAGE_W{1'b0}}, operand};
                            end
                        end
                        RETI: begin
                            pc        <= pcShadow;
                            page      <= pageShadow;
                            acc       <= accShadow;
                            irqActive <= 1'b0;
                        end
                        LD, ADD, SUB: state <= MEMWAIT;
                        HALT:         state <= HALTED;
                        default: ;                  // NOP, ST and unused codes
                    endcase
                end
                MEMWAIT: begin
                    // Read data returns one cycle after dRdEn
                    case (op)
                        ADD:     acc <= acc + dRdData;
                        SUB:     acc <= acc - dRdData;
                        default: acc <= dRdData;
                    endcase
                    state <= FETCH;
                end
                IRQENTRY: begin
                    pc        <= IRQ_VECTOR;
                    page      <= '0;
                    irqActive <= 1'b1;
                    state     <= FETCH;
                end
                HALTED:  state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    //****************************************
    // Instruction register and shadow copies
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= iData;
        end
        if (state == IRQENTRY) begin
            pcShadow   <= pc;       // Next instruction of the interrupted code
            pageShadow <= page;
            accShadow  <= acc;
        end
    end

endmodule

`default_nettype wire

// File: dataRam.sv
`default_nettype none

module dataRam (
    input  logic                      clk,
    input  logic [sysPkg::ADDR_W-1:0] addr,
    input  logic [sysPkg::DATA_W-1:0] wrData,
    input  logic                      wrEn,
    input  logic                      rdEn,
    output logic [sysPkg::DATA_W-1:0] rdData
);
    import sysPkg::*;

    localparam int DEPTH = 2048;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr[IDX_W-1:0]] <= wrData;
        end
        if (rdEn) begin
            rdData <= mem[addr[IDX_W-1:0]];     // Registered read port
        end
    end

endmodule

`default_nettype wire

// File: files.f
sysPkg.sv
cpu.sv
instrRom.sv
dataRam.sv
busDecoder.sv
ioPort.sv
videoOut.sv
system.sv
tbSystem.sv

// File: instrRom.sv
`default_nettype none

module instrRom (
    input  logic                       clk,
    input  logic [sysPkg::ADDR_W-1:0]  addr,
    input  logic                       rdEn,
    output logic [sysPkg::INSTR_W-1:0] data
);
    import sysPkg::*;

    localparam int DEPTH  = 256;
    localparam int IDX_W  = $clog2(DEPTH);

    logic [INSTR_W-1:0] mem [DEPTH];

    // Fixed program, no write port
    initial begin
        $readmemh("program.hex", mem);
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            data <= mem[addr[IDX_W-1:0]];   // Holds last word otherwise
        end
    end

endmodule

`default_nettype wire

// File: ioPort.sv
`default_nettype none

module ioPort (
    input  logic                      clk,
    input  logic                      rstN,
    // Bus side
    input  logic [sysPkg::ADDR_W-1:0] addr,
    input  logic [sysPkg::DATA_W-1:0] wrData,
    input  logic                      wrEn,
    input  logic                      rdEn,
    output logic [sysPkg::DATA_W-1:0] rdData,
    // Pins
    input  logic [sysPkg::DATA_W-1:0] ioIn,
    input  logic                      ioStrobe,
    output logic [sysPkg::DATA_W-1:0] ioPins,
    // Interrupt
    output logic                      irqFlag,
    input  logic                      irqClr
);
    import sysPkg::*;

    logic [DATA_W-1:0] inReg;   // Byte captured on strobe

    //****************************************
    // Output register and interrupt flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ioPins  <= '0;
            irqFlag <= 1'b0;
        end else begin
            if (wrEn && (addr == IO_OUT_ADDR)) begin
                ioPins <= wrData;
            end
            if (ioStrobe) begin
                irqFlag <= 1'b1;    // New strobe beats a clear
            end else if (irqClr) begin
                irqFlag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioStrobe) begin
            inReg <= ioIn;
        end
        if (rdEn) begin
            if (addr == IO_IN_ADDR) begin
                rdData <= inReg;
            end else if (addr == IO_OUT_ADDR) begin
                rdData <= ioPins;   // Pin register reads back
            end else begin
                rdData <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: program.hex
// Main program clears the running sum in data RAM, then idles
1000    // 00 LDI  0
3000    // 01 ST   sum at 0x0000
7002    // 02 JMP  0x002
0000    // 03 NOP
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000    // 0F NOP
// Interrupt service routine at IRQ_VECTOR
6001    // 10 PAGE 1
2001    // 11 LD   input byte at 0x1001
6000    // 12 PAGE 0
4000    // 13 ADD  sum
3000    // 14 ST   sum
6001    // 15 PAGE 1
3000    // 16 ST   output pins at 0x1000
6002    // 17 PAGE 2
3000    // 18 ST   video cell 0 at 0x2000
9000    // 19 RETI

// File: sysPkg.sv
`default_nettype none

package sysPkg;

    //****************************************
    // Bus widths
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 8;
    localparam int INSTR_W = 16;

    //****************************************
    // Memory map
    localparam logic [ADDR_W-1:0] DMEM_LO = 16'h0000;   // Data RAM
    localparam logic [ADDR_W-1:0] DMEM_HI = 16'h07FF;
    localparam logic [ADDR_W-1:0] IO_LO   = 16'h1000;   // I/O block
    localparam logic [ADDR_W-1:0] IO_HI   = 16'h10FF;
    localparam logic [ADDR_W-1:0] VMEM_LO = 16'h2000;   // Video memory, write only
    localparam logic [ADDR_W-1:0] VMEM_HI = 16'h2960;

    localparam logic [ADDR_W-1:0] IO_OUT_ADDR = 16'h1000;  // Output pins
    localparam logic [ADDR_W-1:0] IO_IN_ADDR  = 16'h1001;  // Latched input byte

    localparam logic [ADDR_W-1:0] IRQ_VECTOR  = 16'h0010;

    //****************************************
    // Instruction word is {opcode[15:12], operand[11:0]}
    // Memory operands use {page, operand}
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        LDI  = 4'h1,    // acc = operand[7:0]
        LD   = 4'h2,    // acc = mem
        ST   = 4'h3,    // mem = acc
        ADD  = 4'h4,    // acc = acc + mem
        SUB  = 4'h5,    // acc = acc - mem
        PAGE = 4'h6,    // page = operand[3:0]
        JMP  = 4'h7,
        JZ   = 4'h8,    // Jump when acc is zero
        RETI = 4'h9,
        HALT = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEMWAIT, IRQENTRY, HALTED
    } cpuStateT;

endpackage

`default_nettype wire

// File: system.sv
`default_nettype none

module system #(
    parameter int hVisible = 16,
    parameter int hFront   = 2,
    parameter int hSync    = 4,
    parameter int hBack    = 2,
    parameter int vVisible = 8,
    parameter int vFront   = 1,
    parameter int vSync    = 2,
    parameter int vBack    = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [sysPkg::DATA_W-1:0] ioIn,
    input  logic                      ioStrobe,
    output logic [sysPkg::DATA_W-1:0] ioPins,
    output logic                      hSyncOut,
    output logic                      vSyncOut,
    output logic                      red,
    output logic                      green,
    output logic                      blue
);
    import sysPkg::*;

    logic [ADDR_W-1:0]  iAddr;
    logic               iRdEn;
    logic [INSTR_W-1:0] iData;
    logic [ADDR_W-1:0]  dAddr;
    logic [DATA_W-1:0]  dWrData;
    logic [DATA_W-1:0]  dRdData;
    logic               dWrEn;
    logic               dRdEn;
    logic               ramWrEn;
    logic               ramRdEn;
    logic [DATA_W-1:0]  ramRdData;
    logic               ioWrEn;
    logic               ioRdEn;
    logic [DATA_W-1:0]  ioRdData;
    logic               vidWrEn;
    logic               irqFlag;
    logic               irqClr;

    //****************************************
    // Processor and program store
    cpu cpu0 (
        .clk(clk), .rstN(rstN),
        .iAddr(iAddr), .iRdEn(iRdEn), .iData(iData),
        .dAddr(dAddr), .dWrData(dWrData), .dWrEn(dWrEn), .dRdEn(dRdEn),
        .dRdData(dRdData),
        .irqFlag(irqFlag), .irqClr(irqClr)
    );

    instrRom instrRom0 (.clk(clk), .addr(iAddr), .rdEn(iRdEn), .data(iData));

    //****************************************
    // Memory map
    busDecoder busDecoder0 (
        .clk(clk), .rstN(rstN),
        .dAddr(dAddr), .dWrEn(dWrEn), .dRdEn(dRdEn), .dRdData(dRdData),
        .ramWrEn(ramWrEn), .ramRdEn(ramRdEn),
        .ioWrEn(ioWrEn), .ioRdEn(ioRdEn), .vidWrEn(vidWrEn),
        .ramRdData(ramRdData), .ioRdData(ioRdData)
    );

    dataRam dataRam0 (
        .clk(clk), .addr(dAddr), .wrData(dWrData),
        .wrEn(ramWrEn), .rdEn(ramRdEn), .rdData(ramRdData)
    );

    // Pins and interrupt source
    ioPort ioPort0 (
        .clk(clk), .rstN(rstN),
        .addr(dAddr), .wrData(dWrData), .wrEn(ioWrEn), .rdEn(ioRdEn),
        .rdData(ioRdData),
        .ioIn(ioIn), .ioStrobe(ioStrobe), .ioPins(ioPins),
        .irqFlag(irqFlag), .irqClr(irqClr)
    );

    //****************************************
    // Display
    videoOut #(
        .hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) videoOut0 (
        .clk(clk), .rstN(rstN),
        .addr(dAddr), .wrData(dWrData), .wrEn(vidWrEn),
        .hSyncOut(hSyncOut), .vSyncOut(vSyncOut),
        .red(red), .green(green), .blue(blue)
    );

endmodule

`default_nettype wire

// File: tbSystem.sv
`default_nettype none

module tbSystem;
    import sysPkg::*;

    localparam int H_VISIBLE  = 16;
    localparam int H_FRONT    = 2;
    localparam int H_SYNC     = 4;
    localparam int H_BACK     = 2;
    localparam int V_VISIBLE  = 8;
    localparam int V_FRONT    = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 1;
    localparam int H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;    // 24 cycles per line
    localparam int V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;    // 12 lines
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int PINS_LIMIT = 60;     // Strobe to ioPins update
    localparam int ISR_WAIT   = 100;
    localparam int MAX_GAP    = 20;
    localparam logic [31:0] SEED = 32'h7328eab8;

    logic              clk = 1'b0;
    logic              rstN;
    logic [DATA_W-1:0] ioIn;
    logic              ioStrobe;
    logic [DATA_W-1:0] ioPins;
    logic              hSyncOut;
    logic              vSyncOut;
    logic              red;
    logic              green;
    logic              blue;

    int          cycle = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          errBefore;
    int          fd;
    int          nLines;
    int          inByte;
    int          expSum;
    int          t0;
    int          t1;
    int          t2;
    bit          ok0;
    bit          ok1;
    bit          ok2;
    logic [7:0]  lastSum;
    string       line;

    system #(
        .hVisible(H_VISIBLE), .hFront(H_FRONT), .hSync(H_SYNC), .hBack(H_BACK),
        .vVisible(V_VISIBLE), .vFront(V_FRONT), .vSync(V_SYNC), .vBack(V_BACK)
    ) dut0 (
        .clk(clk), .rstN(rstN), .ioIn(ioIn), .ioStrobe(ioStrobe), .ioPins(ioPins),
        .hSyncOut(hSyncOut), .vSyncOut(vSyncOut),
        .red(red), .green(green), .blue(blue)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;     // Read only at falling edges
    end

    //****************************************
    // Check and wait helpers
    task automatic checkValue(input string what, input int got, input int expected);
        checkCount++;
        assert (got == expected) else begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic checkIdleOutputs(input string phase);
        checkValue({"ioPins ", phase}, int'(ioPins), 0);
        checkValue({"hSyncOut ", phase}, int'(hSyncOut), 1);
        checkValue({"vSyncOut ", phase}, int'(vSyncOut), 1);
        checkValue({"colour ", phase}, int'({red, green, blue}), 0);
    endtask

    task automatic reportTest(input string name, input int errStart);
        $display("Test %s done, %0d errors", name, errorCount - errStart);
    endtask

    // Edge of hSyncOut or vSyncOut, seen at falling clock edges
    task automatic waitSyncEdge(input bit useV, input bit rising, input int limit,
                                output int edgeCycle, output bit seen);
        logic prev;
        logic level;
        int   n;
        seen      = 1'b0;
        edgeCycle = 0;
        n         = 0;
        @(negedge clk);
        prev = useV ? vSyncOut : hSyncOut;
        while (!seen && n < limit) begin
            @(negedge clk);
            level = useV ? vSyncOut : hSyncOut;
            if (level != prev && level == rising) begin
                seen      = 1'b1;
                edgeCycle = cycle;
            end
            prev = level;
            n++;
        end
        if (!seen) begin
            $display("Timeout: no %s %s edge within %0d cycles",
                     useV ? "vSyncOut" : "hSyncOut", rising ? "rising" : "falling", limit);
            errorCount++;
        end
    endtask

    // One input byte through the interrupt routine
    task automatic strobeAndCheck(input int value, input int expected);
        int gap;
        int n;
        bit seen;
        gap  = int'($urandom % (MAX_GAP + 1));
        seen = 1'b0;
        n    = 0;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        ioIn     <= value[DATA_W-1:0];
        ioStrobe <= 1'b1;
        @(posedge clk);
        ioStrobe <= 1'b0;
        while (!seen && n < PINS_LIMIT) begin
            @(negedge clk);
            seen = (ioPins == expected[DATA_W-1:0]);
            n++;
        end
        checkCount++;
        assert (seen) else begin
            $display("CHECK FAILED at %0t: ioPins is %0h, expected %0h within %0d cycles",
                     $time, ioPins, expected, PINS_LIMIT);
            errorCount++;
        end
        repeat (ISR_WAIT) @(posedge clk);
        @(negedge clk);
        checkValue("ioPins after service routine", int'(ioPins), expected);
    endtask

    //****************************************
    // Test sequence
    initial begin
        void'($urandom(SEED));
        rstN     = 1'b0;
        ioIn     = '0;
        ioStrobe = 1'b0;
        nLines   = 0;
        lastSum  = '0;

        errBefore = errorCount;
        repeat (2) begin
            @(negedge clk);
            checkIdleOutputs("in reset");
        end
        @(posedge clk);
        rstN <= 1'b1;           // Third rising edge under reset
        @(negedge clk);
        checkIdleOutputs("after reset");
        reportTest("reset state", errBefore);

        errBefore = errorCount;
        waitSyncEdge(1'b0, 1'b0, 2 * H_TOTAL, t0, ok0);
        waitSyncEdge(1'b0, 1'b1, H_TOTAL, t1, ok1);
        waitSyncEdge(1'b0, 1'b0, H_TOTAL, t2, ok2);
        if (ok0 && ok1 && ok2) begin
            checkValue("hSyncOut low time", t1 - t0, H_SYNC);
            checkValue("hSyncOut period", t2 - t0, H_TOTAL);
        end
        reportTest("horizontal timing", errBefore);

        errBefore = errorCount;
        waitSyncEdge(1'b1, 1'b0, FRAME + H_TOTAL, t0, ok0);
        waitSyncEdge(1'b1, 1'b1, FRAME, t1, ok1);
        waitSyncEdge(1'b1, 1'b0, FRAME, t2, ok2);
        if (ok0 && ok1 && ok2) begin
            checkValue("vSyncOut low time", t1 - t0, V_SYNC * H_TOTAL);
            checkValue("vSyncOut period", t2 - t0, FRAME);
        end
        reportTest("vertical timing", errBefore);

        errBefore = errorCount;
        fd = $fopen("testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testdata.txt for reading");
            errorCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 1) != "//" &&
                    $sscanf(line, "%h %h", inByte, expSum) == 2) begin
                    strobeAndCheck(inByte, expSum);
                    lastSum = expSum[7:0];
                    nLines++;
                end
            end
            $fclose(fd);
        end
        if (nLines == 0) begin
            $display("No input lines were read from testdata.txt");
            errorCount++;
        end
        reportTest("accumulation", errBefore);

        // Pixel (0,0) comes hSync + hBack cycles after the first hSyncOut fall of the frame
        errBefore = errorCount;
        waitSyncEdge(1'b1, 1'b1, FRAME + H_TOTAL, t0, ok0);
        waitSyncEdge(1'b0, 1'b0, H_TOTAL, t1, ok1);
        if (ok0 && ok1) begin
            repeat (H_SYNC + H_BACK) @(negedge clk);
            checkValue("red at pixel 0", int'(red), int'(lastSum[2]));
            checkValue("green at pixel 0", int'(green), int'(lastSum[1]));
            checkValue("blue at pixel 0", int'(blue), int'(lastSum[0]));
        end
        reportTest("video write", errBefore);

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testdata.txt
// Column 1: input byte strobed into ioIn (hex)
// Column 2: expected running sum modulo 256 on ioPins (hex)
05 05
13 18
2A 42
7F C1
80 41
FF 40
01 41
3C 7D
99 16
00 16
64 7A
A5 1F
5A 79
C3 3C
0E 4A
27 71
8B FC
01 FD

// File: videoOut.sv
`default_nettype none

module videoOut #(
    parameter int hVisible = 16,
    parameter int hFront   = 2,
    parameter int hSync    = 4,
    parameter int hBack    = 2,
    parameter int vVisible = 8,
    parameter int vFront   = 1,
    parameter int vSync    = 2,
    parameter int vBack    = 1
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [sysPkg::ADDR_W-1:0] addr,
    input  logic [sysPkg::DATA_W-1:0] wrData,
    input  logic                      wrEn,
    output logic                      hSyncOut,
    output logic                      vSyncOut,
    output logic                      red,
    output logic                      green,
    output logic                      blue
);
    import sysPkg::*;

    localparam int H_TOTAL  = hVisible + hFront + hSync + hBack;
    localparam int V_TOTAL  = vVisible + vFront + vSync + vBack;
    localparam int HS_START = hVisible + hFront;
    localparam int VS_START = vVisible + vFront;
    localparam int H_W      = $clog2(H_TOTAL);
    localparam int V_W      = $clog2(V_TOTAL);
    localparam int V_DEPTH  = int'(VMEM_HI - VMEM_LO) + 1;
    localparam int IDX_W    = $clog2(V_DEPTH);

    logic [2:0]        vmem [V_DEPTH];      // RGB per cell
    logic [H_W-1:0]    hCount;
    logic [V_W-1:0]    vCount;
    logic [ADDR_W-1:0] wrOffset;
    logic [IDX_W-1:0]  rdIdx;
    logic              hSyncNow;
    logic              vSyncNow;
    logic              visible;
    logic              hSync1;
    logic              vSync1;
    logic              visible1;
    logic [2:0]        pix1;

    assign wrOffset = addr - VMEM_LO;
    assign rdIdx    = IDX_W'(int'(vCount) * hVisible + int'(hCount));
    assign visible  = (int'(hCount) < hVisible) && (int'(vCount) < vVisible);
    // Active low pulses
    assign hSyncNow = !((int'(hCount) >= HS_START) && (int'(hCount) < HS_START + hSync));
    assign vSyncNow = !((int'(vCount) >= VS_START) && (int'(vCount) < VS_START + vSync));

    initial begin
        for (int i = 0; i < V_DEPTH; i++) begin
            vmem[i] = '0;
        end
    end

    //****************************************
    // Scan counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (int'(hCount) == H_TOTAL - 1) begin
            hCount <= '0;
            vCount <= (int'(vCount) == V_TOTAL - 1) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Memory write port and pixel fetch, first stage
    always_ff @(posedge clk) begin
        if (wrEn) begin
            vmem[wrOffset[IDX_W-1:0]] <= wrData[2:0];
        end
        pix1 <= vmem[rdIdx];
    end

    //****************************************
    // Sync and colour pipeline
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hSync1   <= 1'b1;
            vSync1   <= 1'b1;
            visible1 <= 1'b0;
            hSyncOut <= 1'b1;
            vSyncOut <= 1'b1;
            {red, green, blue} <= 3'b000;
        end else begin
            hSync1   <= hSyncNow;
            vSync1   <= vSyncNow;
            visible1 <= visible;
            hSyncOut <= hSync1;
            vSyncOut <= vSync1;
            {red, green, blue} <= visible1 ? pix1 : 3'b000;  // Blank outside the picture
        end
    end

endmodule

`default_nettype wire
